// ==== hw/bus_decode.sv ====
// address decode for the control block
// the master must hold address and strobes stable while mem_valid is high
// any access with mem_wstrb[0] set counts as a write, partial strobes are not honoured
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
	input  wire logic             mem_valid,
	input  soc_pkg::addr_t        mem_addr,
	input  soc_pkg::strb_t        mem_wstrb,
	output logic                  misc_sel,
	output logic                  reg_wr,
	output soc_pkg::reg_idx_t     reg_idx,
	output logic                  bus_err
);

	import soc_pkg::*;

	logic region_hit;
	logic is_write;

	// only the misc region exists in this slice of the SoC
	assign region_hit = (mem_addr[31:28] == REGION_MISC);

	assign is_write = mem_wstrb[0];

	// word index inside the misc region
	assign reg_idx = mem_addr[6:2];

	assign misc_sel = mem_valid && region_hit;

	// every other region answers with an error
	assign bus_err = mem_valid && !region_hit;

	assign reg_wr = misc_sel && is_write;

endmodule

`default_nettype wire

// ==== hw/fsel_sequencer.sv ====
// clocks the flash-select flip-flop and optionally pulls PROGRAMN
// with the write as cycle 0, fsel_c is high in cycles 3 to 5 and PROGRAMN falls in cycle 8
// once low, PROGRAMN only returns high through rst
`timescale 1ns/1ps
`default_nettype none

module fsel_sequencer (
	input  wire logic clk48m,
	input  wire logic rst,
	input  wire logic fsel_go,
	input  wire logic reload_req,
	output logic      fsel_c,
	output logic      programn
);

	import soc_pkg::*;

	logic [$bits(FSEL_LOAD)-1:0] fsel_delay;
	logic                        reload_pend;
	logic                        fpga_reload;

	// clock pulse sits in the middle of the count so fsel_d has settled
	assign fsel_c = (fsel_delay == 3'd5) || (fsel_delay == 3'd4) || (fsel_delay == 3'd3);

	assign programn = ~fpga_reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay  <= '0;
			reload_pend <= 1'b0;
			fpga_reload <= 1'b0;
		end else if (fsel_go) begin
			// a new write restarts the sequence
			fsel_delay  <= FSEL_LOAD;
			reload_pend <= reload_req;
		end else if (fsel_delay != '0) begin
			fsel_delay <= fsel_delay - 1'b1;
			if (fsel_delay == 3'd1 && reload_pend) begin
				fpga_reload <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/gpio_bank.sv ====
// one GPIO bank: output and output-enable registers plus write-to-set and write-to-clear
// the strobes are expected to be mutually exclusive, out takes priority if not
// pin inputs are not registered here, they are read straight from the pads
`timescale 1ns/1ps
`default_nettype none

module gpio_bank #(
	parameter type payload_t = logic [7:0]
) (
	input  wire logic clk48m,
	input  wire logic rst,
	input  wire logic wr_out,
	input  wire logic wr_oe,
	input  wire logic wr_set,
	input  wire logic wr_clr,
	input  payload_t  wdata,
	output payload_t  pin_out,
	output payload_t  pin_oe
);

	// output value register
	always_ff @(posedge clk48m) begin
		if (rst) begin
			pin_out <= '0;
		end else if (wr_out) begin
			pin_out <= wdata;
		end else if (wr_set) begin
			pin_out <= pin_out | wdata;
		end else if (wr_clr) begin
			// ones in wdata clear the matching pins
			pin_out <= pin_out & ~wdata;
		end
	end

	// direction register, 1 drives the pin
	always_ff @(posedge clk48m) begin
		if (rst) begin
			pin_oe <= '0;
		end else if (wr_oe) begin
			pin_oe <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== hw/misc_regs.sv ====
// write side of the misc registers
// writes land on the clock edge that ends the access and are visible one cycle later
// fsel_go and reload_req are combinational and only valid during the write cycle
`timescale 1ns/1ps
`default_nettype none

module misc_regs (
	input  wire logic          clk48m,
	input  wire logic          rst,
	input  wire logic          reg_wr,
	input  soc_pkg::reg_idx_t  reg_idx,
	input  soc_pkg::data_t     wdata,
	output soc_pkg::led_t      led,
	output logic               trace_en,
	output logic               fsel_d,
	output logic               fsel_go,
	output logic               reload_req,
	output soc_pkg::genio_t    genio_out,
	output soc_pkg::genio_t    genio_oe,
	output soc_pkg::pmod_t     pmod_out,
	output soc_pkg::pmod_t     pmod_oe
);

	import soc_pkg::*;

	genio_t genio_wdata;
	pmod_t  pmod_wdata;

	assign genio_wdata = wdata[$bits(genio_t)-1:0];
	// pmod lives in its own byte of the GPEXT word
	assign pmod_wdata = wdata[PMOD_LSB +: $bits(pmod_t)];

	assign fsel_go = reg_wr && (reg_idx == REG_FLASH_SEL);
	// D0F1A5xx in a flash-select write requests a reconfiguration
	assign reload_req = fsel_go && (wdata[31:8] == FLASH_MAGIC);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led      <= '0;
			trace_en <= 1'b0;
			fsel_d   <= 1'b0;
		end else if (reg_wr) begin
			case (reg_idx)
				REG_LED:       led <= wdata[$bits(led_t)-1:0];
				// version is read-only, its write slot holds trace enable
				REG_SOC_VER:   trace_en <= wdata[0];
				REG_FLASH_SEL: fsel_d <= wdata[0];
				default: ;
			endcase
		end
	end

	gpio_bank #(
		.payload_t(genio_t)
	) genio_bank (
		.clk48m  (clk48m),
		.rst     (rst),
		.wr_out  (reg_wr && (reg_idx == REG_GENIO_OUT)),
		.wr_oe   (reg_wr && (reg_idx == REG_GENIO_OE)),
		.wr_set  (reg_wr && (reg_idx == REG_GENIO_W2S)),
		.wr_clr  (reg_wr && (reg_idx == REG_GENIO_W2C)),
		.wdata   (genio_wdata),
		.pin_out (genio_out),
		.pin_oe  (genio_oe)
	);

	gpio_bank #(
		.payload_t(pmod_t)
	) pmod_bank (
		.clk48m  (clk48m),
		.rst     (rst),
		.wr_out  (reg_wr && (reg_idx == REG_GPEXT_OUT)),
		.wr_oe   (reg_wr && (reg_idx == REG_GPEXT_OE)),
		.wr_set  (reg_wr && (reg_idx == REG_GPEXT_W2S)),
		.wr_clr  (reg_wr && (reg_idx == REG_GPEXT_W2C)),
		.wdata   (pmod_wdata),
		.pin_out (pmod_out),
		.pin_oe  (pmod_oe)
	);

endmodule

`default_nettype wire

// ==== hw/read_mux.sv ====
// read data, ready and bus-error interrupt for every access
// every access completes in the cycle it is presented, no wait states
// unmapped indexes inside the misc region read zero
`timescale 1ns/1ps
`default_nettype none

module read_mux #(
	parameter soc_pkg::data_t SOC_VERSION = '0
) (
	input  wire logic          misc_sel,
	input  wire logic          bus_err,
	input  soc_pkg::reg_idx_t  reg_idx,
	input  soc_pkg::btn_t      btn,
	input  soc_pkg::led_t      led,
	input  wire logic          fsel_d,
	input  soc_pkg::genio_t    genio_in,
	input  soc_pkg::genio_t    genio_out,
	input  soc_pkg::genio_t    genio_oe,
	input  soc_pkg::pmod_t     pmod_in,
	input  soc_pkg::pmod_t     pmod_out,
	input  soc_pkg::pmod_t     pmod_oe,
	output soc_pkg::data_t     mem_rdata,
	output logic               mem_ready,
	output logic               bus_err_irq
);

	import soc_pkg::*;

	localparam int GW = $bits(genio_t);
	localparam int PW = $bits(pmod_t);

	always_comb begin
		mem_rdata = '0;
		if (bus_err) begin
			mem_rdata = BUS_ERR_DATA;
		end else if (misc_sel) begin
			case (reg_idx)
				REG_LED:       mem_rdata[$bits(led_t)-1:0] = led;
				// buttons are active low on the board
				REG_BTN:       mem_rdata[$bits(btn_t)-1:0] = ~btn;
				REG_SOC_VER:   mem_rdata = SOC_VERSION;
				REG_FLASH_SEL: mem_rdata[0] = fsel_d;
				REG_GENIO_IN:  mem_rdata[GW-1:0] = genio_in;
				REG_GENIO_OUT: mem_rdata[GW-1:0] = genio_out;
				REG_GENIO_OE:  mem_rdata[GW-1:0] = genio_oe;
				REG_GPEXT_IN:  mem_rdata[PMOD_LSB +: PW] = pmod_in;
				REG_GPEXT_OUT: mem_rdata[PMOD_LSB +: PW] = pmod_out;
				REG_GPEXT_OE:  mem_rdata[PMOD_LSB +: PW] = pmod_oe;
				default: ;
			endcase
		end
	end

	assign mem_ready = misc_sel || bus_err;

	// irq 3 of the CPU, high for the length of the bad access only
	assign bus_err_irq = bus_err;

endmodule

`default_nettype wire

// ==== hw/soc_io.sv ====
// memory-mapped control block of the SoC: misc registers, GPIO and flash-select sequencing
// single bus slave with zero wait states; ready follows valid in the same cycle
// rst is synchronous and active high, PROGRAMN stays low after a reload until rst
`timescale 1ns/1ps
`default_nettype none

module soc_io #(
	parameter soc_pkg::data_t SOC_VERSION = '0
) (
	input  wire logic        clk48m,
	input  wire logic        rst,
	input  wire logic        mem_valid,
	input  soc_pkg::addr_t   mem_addr,
	input  soc_pkg::data_t   mem_wdata,
	input  soc_pkg::strb_t   mem_wstrb,
	input  soc_pkg::btn_t    btn,
	input  soc_pkg::genio_t  genio_in,
	input  soc_pkg::pmod_t   pmod_in,
	output soc_pkg::data_t   mem_rdata,
	output logic             mem_ready,
	output logic             bus_err_irq,
	output soc_pkg::led_t    led,
	output logic             trace_en,
	output logic             fsel_d,
	output logic             fsel_c,
	output logic             programn,
	output soc_pkg::genio_t  genio_out,
	output soc_pkg::genio_t  genio_oe,
	output soc_pkg::pmod_t   pmod_out,
	output soc_pkg::pmod_t   pmod_oe
);

	import soc_pkg::*;

	logic     misc_sel;
	logic     reg_wr;
	reg_idx_t reg_idx;
	logic     bus_err;
	logic     fsel_go;
	logic     reload_req;

	bus_decode u_decode (
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wstrb (mem_wstrb),
		.misc_sel  (misc_sel),
		.reg_wr    (reg_wr),
		.reg_idx   (reg_idx),
		.bus_err   (bus_err)
	);

	misc_regs u_regs (
		.clk48m     (clk48m),
		.rst        (rst),
		.reg_wr     (reg_wr),
		.reg_idx    (reg_idx),
		.wdata      (mem_wdata),
		.led        (led),
		.trace_en   (trace_en),
		.fsel_d     (fsel_d),
		.fsel_go    (fsel_go),
		.reload_req (reload_req),
		.genio_out  (genio_out),
		.genio_oe   (genio_oe),
		.pmod_out   (pmod_out),
		.pmod_oe    (pmod_oe)
	);

	fsel_sequencer u_fsel (
		.clk48m     (clk48m),
		.rst        (rst),
		.fsel_go    (fsel_go),
		.reload_req (reload_req),
		.fsel_c     (fsel_c),
		.programn   (programn)
	);

	read_mux #(
		.SOC_VERSION(SOC_VERSION)
	) u_result (
		.misc_sel    (misc_sel),
		.bus_err     (bus_err),
		.reg_idx     (reg_idx),
		.btn         (btn),
		.led         (led),
		.fsel_d      (fsel_d),
		.genio_in    (genio_in),
		.genio_out   (genio_out),
		.genio_oe    (genio_oe),
		.pmod_in     (pmod_in),
		.pmod_out    (pmod_out),
		.pmod_oe     (pmod_oe),
		.mem_rdata   (mem_rdata),
		.mem_ready   (mem_ready),
		.bus_err_irq (bus_err_irq)
	);

endmodule

`default_nettype wire

// ==== hw/soc_pkg.sv ====
// shared bus, register-index and pin-field definitions for the SoC control block
// only the misc region (top address nibble 2) is decoded, everything else is a bus error
// register indexes are word offsets taken from address bits 6:2
`default_nettype none

package soc_pkg;

	// bus words
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;

	// misc register index, address bits 6:2
	typedef logic [4:0] reg_idx_t;

	// pin fields
	typedef logic [15:0] led_t;
	typedef logic [7:0]  btn_t;
	typedef logic [29:0] genio_t;
	typedef logic [7:0]  pmod_t;

	localparam logic [3:0] REGION_MISC = 4'h2;

	localparam reg_idx_t REG_LED       = 5'd0;
	localparam reg_idx_t REG_BTN       = 5'd1;
	localparam reg_idx_t REG_SOC_VER   = 5'd2;
	localparam reg_idx_t REG_FLASH_SEL = 5'd13;
	localparam reg_idx_t REG_GENIO_IN  = 5'd17;
	localparam reg_idx_t REG_GENIO_OUT = 5'd18;
	localparam reg_idx_t REG_GENIO_OE  = 5'd19;
	localparam reg_idx_t REG_GENIO_W2S = 5'd20;
	localparam reg_idx_t REG_GENIO_W2C = 5'd21;
	localparam reg_idx_t REG_GPEXT_IN  = 5'd22;
	localparam reg_idx_t REG_GPEXT_OUT = 5'd23;
	localparam reg_idx_t REG_GPEXT_OE  = 5'd24;
	localparam reg_idx_t REG_GPEXT_W2S = 5'd25;
	localparam reg_idx_t REG_GPEXT_W2C = 5'd26;

	// pmod field position inside the GPEXT words
	localparam int PMOD_LSB = 16;

	// read word returned for an undecoded address
	localparam data_t BUS_ERR_DATA = 32'hDEADBEEF;

	// upper 24 bits of a flash-select write that asks for a reload
	localparam logic [23:0] FLASH_MAGIC = 24'hD0F1A5;

	// flash-select sequencer start count
	localparam logic [2:0] FSEL_LOAD = 3'd7;

endpackage

`default_nettype wire

// ==== list.f ====
hw/soc_pkg.sv
hw/bus_decode.sv
hw/gpio_bank.sv
hw/misc_regs.sv
hw/fsel_sequencer.sv
hw/read_mux.sv
hw/soc_io.sv
testbench/soc_chk.sv
testbench/tb_soc.sv

// ==== testbench/soc_chk.sv ====
// bus and reload properties of the control block bound into soc_io
// expects inputs driven away from the rising edge of clk48m
`timescale 1ns/1ps
`default_nettype none

module soc_chk (
	input wire logic clk48m,
	input wire logic rst,
	input wire logic mem_valid,
	input wire logic mem_ready,
	input wire logic bus_err_irq,
	input wire logic programn
);

	// assertion failures so far, added to the testbench totals
	int fail_count = 0;

	// zero wait states so every access is answered at once
	a_ready_follows_valid: assert property (@(posedge clk48m) mem_ready == mem_valid)
		else begin
			$error("mem_ready differs from mem_valid");
			fail_count++;
		end

	a_irq_needs_valid: assert property (@(posedge clk48m) bus_err_irq |-> mem_valid)
		else begin
			$error("bus_err_irq high without an access");
			fail_count++;
		end

	// reload is sticky until reset
	a_programn_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn |=> !programn)
		else begin
			$error("programn returned high without reset");
			fail_count++;
		end

endmodule

bind soc_io soc_chk chk (
	.clk48m      (clk48m),
	.rst         (rst),
	.mem_valid   (mem_valid),
	.mem_ready   (mem_ready),
	.bus_err_irq (bus_err_irq),
	.programn    (programn)
);

`default_nettype wire

// ==== testbench/tb_soc.sv ====
// directed tests for the control block with the testbench as bus master
// bus inputs change 1 ns after the rising edge and outputs are sampled mid-cycle
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	import soc_pkg::*;

	localparam data_t SOC_VER = 32'h0002_0107;
	localparam int TEST_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

	logic    clk48m;
	logic    rst;
	logic    mem_valid;
	addr_t   mem_addr;
	data_t   mem_wdata;
	strb_t   mem_wstrb;
	btn_t    btn;
	genio_t  genio_in;
	pmod_t   pmod_in;
	data_t   mem_rdata;
	logic    mem_ready;
	logic    bus_err_irq;
	led_t    led;
	logic    trace_en;
	logic    fsel_d;
	logic    fsel_c;
	logic    programn;
	genio_t  genio_out;
	genio_t  genio_oe;
	pmod_t   pmod_out;
	pmod_t   pmod_oe;

	int          n_pass = 0;
	int          n_fail = 0;
	int          cycle_count = 0;
	logic [15:0] lfsr;

	soc_io #(
		.SOC_VERSION(SOC_VER)
	) DUT (
		.clk48m(clk48m), .rst(rst),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .btn(btn), .genio_in(genio_in), .pmod_in(pmod_in),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready), .bus_err_irq(bus_err_irq),
		.led(led), .trace_en(trace_en), .fsel_d(fsel_d), .fsel_c(fsel_c),
		.programn(programn), .genio_out(genio_out), .genio_oe(genio_oe),
		.pmod_out(pmod_out), .pmod_oe(pmod_oe)
	);

	always #10 clk48m = ~clk48m;

	// 16-bit Galois LFSR stepped once per bit taken
	function automatic data_t rand_bits(input int n);
		data_t v;
		logic  b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 16'hB400;
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic addr_t misc_addr(input reg_idx_t idx);
		return {REGION_MISC, 21'd0, idx, 2'b00};
	endfunction

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			n_fail++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end else
			n_pass++;
	endtask

	task automatic check_genio(input string name, input genio_t exp, input genio_t act);
		if (act !== exp) begin
			n_fail++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end else
			n_pass++;
	endtask

	task automatic check_pmod(input string name, input pmod_t exp, input pmod_t act);
		if (act !== exp) begin
			n_fail++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end else
			n_pass++;
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			n_fail++;
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
		end else
			n_pass++;
	endtask

	// one-cycle access entered and left 1 ns after a rising edge
	task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t strb,
			output data_t rdata);
		logic exp_err;
		exp_err = (addr[31:28] != REGION_MISC);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = strb;
		#5;
		rdata = mem_rdata;
		check_bit("mem_ready", 1'b1, mem_ready);
		check_bit("bus_err_irq", exp_err, bus_err_irq);
		@(posedge clk48m);
		#1;
		mem_valid = 1'b0;
		mem_wstrb = '0;
	endtask

	task automatic bus_write(input addr_t addr, input data_t wdata);
		data_t rd;
		bus_access(addr, wdata, 4'hF, rd);
	endtask

	task automatic check_read(input string name, input addr_t addr, input data_t exp);
		data_t rd;
		bus_access(addr, '0, 4'h0, rd);
		check_data(name, exp, rd);
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (n_fail == fails_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d checks failed", name, n_fail - fails_before);
	endtask

	task automatic test_reset_regs();
		int   fails_before;
		btn_t nb;
		fails_before = n_fail;
		check_data("led", '0, data_t'(led));
		check_genio("genio_out", '0, genio_out);
		check_genio("genio_oe", '0, genio_oe);
		check_pmod("pmod_out", '0, pmod_out);
		check_pmod("pmod_oe", '0, pmod_oe);
		check_bit("fsel_d", 1'b0, fsel_d);
		check_bit("fsel_c", 1'b0, fsel_c);
		check_bit("programn", 1'b1, programn);
		check_bit("trace_en", 1'b0, trace_en);
		check_read("REG_SOC_VER", misc_addr(REG_SOC_VER), SOC_VER);
		btn = btn_t'(rand_bits(8));
		nb = ~btn;
		check_read("REG_BTN", misc_addr(REG_BTN), data_t'(nb));
		// upper half of the write must be dropped
		bus_write(misc_addr(REG_LED), 32'h1234_A5C3);
		check_data("led", 32'h0000_A5C3, data_t'(led));
		check_read("REG_LED", misc_addr(REG_LED), 32'h0000_A5C3);
		bus_write(misc_addr(REG_SOC_VER), 32'h0000_0001);
		check_bit("trace_en", 1'b1, trace_en);
		check_read("REG_SOC_VER", misc_addr(REG_SOC_VER), SOC_VER);
		report_test("reset and simple registers", fails_before);
	endtask

	task automatic test_genio();
		int     fails_before;
		genio_t m_out;
		genio_t m_oe;
		genio_t val;
		data_t  w;
		fails_before = n_fail;
		m_out = '0;
		m_oe = '0;
		for (int i = 0; i < 12; i++) begin
			val = genio_t'(rand_bits(30));
			w = rand_bits(32);
			w[29:0] = val;
			genio_in = genio_t'(rand_bits(30));
			case (i % 4)
				0: begin
					bus_write(misc_addr(REG_GENIO_OUT), w);
					m_out = val;
				end
				1: begin
					bus_write(misc_addr(REG_GENIO_OE), w);
					m_oe = val;
				end
				2: begin
					bus_write(misc_addr(REG_GENIO_W2S), w);
					m_out = m_out | val;
				end
				default: begin
					bus_write(misc_addr(REG_GENIO_W2C), w);
					m_out = m_out & ~val;
				end
			endcase
			check_genio("genio_out", m_out, genio_out);
			check_genio("genio_oe", m_oe, genio_oe);
			check_read("REG_GENIO_OUT", misc_addr(REG_GENIO_OUT), data_t'(m_out));
			check_read("REG_GENIO_OE", misc_addr(REG_GENIO_OE), data_t'(m_oe));
			check_read("REG_GENIO_IN", misc_addr(REG_GENIO_IN), data_t'(genio_in));
		end
		report_test("general io bank", fails_before);
	endtask

	task automatic test_pmod();
		int    fails_before;
		pmod_t m_out;
		pmod_t m_oe;
		pmod_t val;
		data_t w;
		fails_before = n_fail;
		m_out = '0;
		m_oe = '0;
		for (int i = 0; i < 12; i++) begin
			val = pmod_t'(rand_bits(8));
			// random bits around the field must be ignored
			w = rand_bits(32);
			w[PMOD_LSB +: 8] = val;
			pmod_in = pmod_t'(rand_bits(8));
			case (i % 4)
				0: begin
					bus_write(misc_addr(REG_GPEXT_OUT), w);
					m_out = val;
				end
				1: begin
					bus_write(misc_addr(REG_GPEXT_OE), w);
					m_oe = val;
				end
				2: begin
					bus_write(misc_addr(REG_GPEXT_W2S), w);
					m_out = m_out | val;
				end
				default: begin
					bus_write(misc_addr(REG_GPEXT_W2C), w);
					m_out = m_out & ~val;
				end
			endcase
			check_pmod("pmod_out", m_out, pmod_out);
			check_pmod("pmod_oe", m_oe, pmod_oe);
			check_read("REG_GPEXT_OUT", misc_addr(REG_GPEXT_OUT), data_t'(m_out) << PMOD_LSB);
			check_read("REG_GPEXT_OE", misc_addr(REG_GPEXT_OE), data_t'(m_oe) << PMOD_LSB);
			check_read("REG_GPEXT_IN", misc_addr(REG_GPEXT_IN), data_t'(pmod_in) << PMOD_LSB);
		end
		report_test("pmod bank", fails_before);
	endtask

	task automatic test_bus_error();
		int     fails_before;
		addr_t  a;
		led_t   s_led;
		genio_t s_gout;
		genio_t s_goe;
		pmod_t  s_pout;
		pmod_t  s_poe;
		logic   s_trace;
		logic   s_fsel;
		fails_before = n_fail;
		s_led = led;
		s_gout = genio_out;
		s_goe = genio_oe;
		s_pout = pmod_out;
		s_poe = pmod_oe;
		s_trace = trace_en;
		s_fsel = fsel_d;
		a = rand_bits(32);
		a[31:28] = 4'h5;
		check_read("bus error read", a, BUS_ERR_DATA);
		// all ones and then all zeros at every misc offset of two undecoded regions
		for (int k = 0; k < 2; k++) begin
			for (int i = 0; i < 32; i++) begin
				a = misc_addr(reg_idx_t'(i));
				a[31:28] = (k == 0) ? 4'h0 : 4'hF;
				bus_write(a, (k == 0) ? 32'hFFFF_FFFF : 32'h0000_0000);
			end
			#5;
			check_bit("bus_err_irq", 1'b0, bus_err_irq);
			check_data("led", data_t'(s_led), data_t'(led));
			check_genio("genio_out", s_gout, genio_out);
			check_genio("genio_oe", s_goe, genio_oe);
			check_pmod("pmod_out", s_pout, pmod_out);
			check_pmod("pmod_oe", s_poe, pmod_oe);
			check_bit("trace_en", s_trace, trace_en);
			check_bit("fsel_d", s_fsel, fsel_d);
			@(posedge clk48m);
			#1;
		end
		check_read("unmapped index 5", misc_addr(5'd5), '0);
		check_read("unmapped index 31", misc_addr(5'd31), '0);
		report_test("bus error", fails_before);
	endtask

	// cycle n counts from the write cycle as 0 and the task starts in cycle 1
	task automatic watch_fsel(input logic exp_d, input logic reload, input int n_cycles);
		for (int n = 1; n <= n_cycles; n++) begin
			#5;
			check_bit("fsel_d", exp_d, fsel_d);
			check_bit("fsel_c", (n >= 3) && (n <= 5), fsel_c);
			check_bit("programn", !(reload && n >= 8), programn);
			@(posedge clk48m);
			#1;
		end
	endtask

	task automatic test_flash_sel();
		int fails_before;
		fails_before = n_fail;
		bus_write(misc_addr(REG_FLASH_SEL), 32'h0000_0001);
		watch_fsel(1'b1, 1'b0, 20);
		check_read("REG_FLASH_SEL", misc_addr(REG_FLASH_SEL), 32'h0000_0001);
		report_test("flash select without reload", fails_before);
	endtask

	task automatic test_flash_reload();
		int fails_before;
		fails_before = n_fail;
		bus_write(misc_addr(REG_FLASH_SEL), {FLASH_MAGIC, 8'h00});
		watch_fsel(1'b0, 1'b1, 20);
		rst = 1'b1;
		repeat (2) begin
			@(posedge clk48m);
			#1;
		end
		rst = 1'b0;
		#5;
		check_bit("programn", 1'b1, programn);
		@(posedge clk48m);
		#1;
		report_test("flash select with reload", fails_before);
	endtask

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk48m);
			cycle_count++;
		end
		$display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk48m = 1'b0;
		rst = 1'b1;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		btn = '0;
		genio_in = '0;
		pmod_in = '0;
		lfsr = 16'd51;
		repeat (10) @(posedge clk48m);
		#1;
		rst = 1'b0;
		test_reset_regs();
		test_genio();
		test_pmod();
		test_bus_error();
		test_flash_sel();
		test_flash_reload();
		$display("checks passed: %0d, checks failed: %0d, assertion failures: %0d",
			n_pass, n_fail, DUT.chk.fail_count);
		if (n_fail == 0 && DUT.chk.fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
